/* src.f */
+incdir+common
common/spiTypes_pkg.sv
common/regTypes_pkg.sv
rtl/spiSync.sv
spiCore/spiFrame.sv
spiCore/spiTransmit.sv
rtl/regBank.sv
rtl/spiPeriph.sv
testbench/spiPeriph_assert.sv
testbench/spiPeriph_tb.sv

/* Makefile */
# Verilator simulation of the SPI register peripheral

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove the build directory and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module spiPeriph_tb -Mdir obj_dir -f src.f
	./obj_dir/VspiPeriph_tb +verilator+error+limit+100 | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/spiPeriph_tb.sv */
// SPI peripheral testbench
`include "spi_macros.svh"

module spiPeriph_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import regTypes_pkg::*;

  localparam int numFrames = 200;
  localparam int clkPeriodNs = 20;
  // sync latency plus the load path, both must fit in one sck phase
  localparam int sckHalf = 2 * (`SPI_SYNC_DEPTH + 1);
  // longest frame is a command and eight data bytes, plus select setup and gap
  localparam int maxFrameSck = 9 * 8 + 3;
  // each loop pass runs up to two frames, plus the read after reset
  localparam int maxFrames = 2 * numFrames + 1;
  // twice the worst case
  localparam int timeoutNs = 2 * maxFrames * maxFrameSck * 2 * sckHalf * clkPeriodNs;

  logic   clk = 1'b0;
  logic   rst;
  logic   sck;
  logic   ssel;
  logic   mosi;
  logic   miso;
  ledBits led;

  // reference copy of the register bank
  logic [7:0] model [`SPI_NUM_REGS];
  int kind;

  spiPeriph dut0 (
    .clk  (clk),
    .rst  (rst),
    .sck  (sck),
    .ssel (ssel),
    .mosi (mosi),
    .miso (miso),
    .led  (led)
  );

  always #10 clk = ~clk;

  task automatic expectEqual(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %s expected %02h actual %02h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // select low, then one sck phase before the first bit
  task automatic beginFrame;
    @(posedge clk);
    ssel <= 1'b0;
    repeat (sckHalf) @(posedge clk);
  endtask

  task automatic endFrame;
    repeat (sckHalf) @(posedge clk);
    ssel <= 1'b1;
    // idle gap so the next frame start is clean
    repeat (2 * sckHalf) @(posedge clk);
  endtask

  // mode 0, msb first, mosi set while sck is low
  task automatic shiftBits(input logic [7:0] dataOut, input int numBits,
                           output logic [7:0] dataIn);
    dataIn = 8'h00;
    for (int i = 7; i > 7 - numBits; i--)
    begin
      mosi <= dataOut[i];
      repeat (sckHalf - 1) @(posedge clk);
      // miso settled long ago, read it half a clk before the rising edge
      @(negedge clk);
      dataIn[i] = miso;
      @(posedge clk);
      sck <= 1'b1;
      repeat (sckHalf) @(posedge clk);
      sck <= 1'b0;
    end
  endtask

  task automatic runFrame(input logic isWrite, input regAddr startAddr,
                          input int numData, input string name);
    logic [7:0] cmd;
    logic [7:0] dataOut;
    logic [7:0] dataIn;
    regAddr     addr;
    // bits 6 to 3 are don't care, so fill them randomly
    cmd = {isWrite, 4'($urandom), startAddr};
    addr = startAddr;
    beginFrame();
    shiftBits(cmd, 8, dataIn);
    expectEqual({name, " id byte"}, `SPI_ID_BYTE, dataIn);
    for (int j = 0; j < numData; j++)
    begin
      // read frames also send random mosi, which must be ignored
      dataOut = 8'($urandom);
      shiftBits(dataOut, 8, dataIn);
      if (isWrite)
      begin
        expectEqual({name, " write miso"}, 8'h00, dataIn);
        model[addr] = dataOut;
      end
      else
      begin
        expectEqual({name, " read data"}, model[addr], dataIn);
      end
      // wraps modulo 8
      addr = addr + 1'b1;
    end
    endFrame();
    expectEqual({name, " led"}, {4'h0, model[0][3:0]}, {4'h0, led});
  endtask

  // select goes high in the middle of a byte
  task automatic abortFrame(input string name);
    logic [7:0] cmd;
    logic [7:0] dataIn;
    int         cutBits;
    // at most six bits, a seventh falling edge would leave the transmitter mid load
    cutBits = $urandom_range(1, 6);
    cmd = {1'b1, 4'($urandom), 3'($urandom)};
    beginFrame();
    if ($urandom_range(0, 1) == 0)
    begin
      shiftBits(cmd, cutBits, dataIn);
    end
    else
    begin
      shiftBits(cmd, 8, dataIn);
      expectEqual({name, " id byte"}, `SPI_ID_BYTE, dataIn);
      shiftBits(8'($urandom), cutBits, dataIn);
    end
    endFrame();
    expectEqual({name, " led"}, {4'h0, model[0][3:0]}, {4'h0, led});
  endtask

  initial
  begin
    void'($urandom(32'h46abddc0));
    for (int i = 0; i < `SPI_NUM_REGS; i++)
    begin
      model[i] = 8'h00;
    end
    rst  <= 1'b1;
    sck  <= 1'b0;
    ssel <= 1'b1;
    mosi <= 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    expectEqual("reset led", 8'h00, {4'h0, led});
    runFrame(1'b0, 3'd0, `SPI_NUM_REGS, "reset read");

    for (int n = 0; n < numFrames; n++)
    begin
      kind = $urandom_range(0, 9);
      if (kind < 5)
      begin
        runFrame(1'b1, 3'($urandom), $urandom_range(1, 5), "write");
        runFrame(1'b0, 3'($urandom), `SPI_NUM_REGS, "read back");
      end
      else if (kind < 9)
      begin
        runFrame(1'b0, 3'($urandom), $urandom_range(1, 8), "read");
      end
      else
      begin
        abortFrame("abort");
        runFrame(1'b0, 3'($urandom), `SPI_NUM_REGS, "read after abort");
      end
    end

    // bound assertions count their own failures
    if (dut0.regs0.assert0.failCount == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("register bank assertions failed %0d times",
               dut0.regs0.assert0.failCount);
      $display("Done: errors found");
      $fatal(1, "assertion failures");
    end
  end

  // watchdog
  initial
  begin
    #(timeoutNs);
    $display("timeout, the SPI frames did not finish in time");
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

endmodule

/* testbench/spiPeriph_assert.sv */
// Register bank assertions
module spiPeriph_assert (
  input logic                    clk,
  input logic                    rst,
  input logic                    rxValid,
  input logic                    txLoad,
  input regTypes_pkg::frameState state,
  input regTypes_pkg::ledBits    led,
  input spiTypes_pkg::spiByte    reg0
);

  timeunit 1ns;
  timeprecision 1ps;

  import regTypes_pkg::*;

  // number of failed assertions so far
  int failCount = 0;

  // a received byte is flagged for exactly one clk
  rxPulse: assert property (@(posedge clk) disable iff (rst) rxValid |=> !rxValid)
  else
  begin
    $error("rxValid held longer than one cycle");
    failCount++;
  end

  // loads only happen inside a frame
  loadInFrame: assert property (@(posedge clk) disable iff (rst) txLoad |-> state != IDLE)
  else
  begin
    $error("txLoad while the FSM is IDLE");
    failCount++;
  end

  // leds trail register 0 by one clk
  ledFollow: assert property (@(posedge clk) disable iff (rst) led == $past(reg0[3:0]))
  else
  begin
    $error("led does not match register 0");
    failCount++;
  end

endmodule

bind regBank spiPeriph_assert assert0 (
  .clk     (clk),
  .rst     (rst),
  .rxValid (rxValid),
  .txLoad  (txLoad),
  .state   (state),
  .led     (led),
  .reg0    (regs[0])
);

/* rtl/spiPeriph.sv */
// SPI register peripheral
module spiPeriph (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sck,
  input  logic                 ssel,
  input  logic                 mosi,
  output logic                 miso,
  output regTypes_pkg::ledBits led
);

  import spiTypes_pkg::*;

  // synchronized strobes and levels
  logic   sckRise;
  logic   sckFall;
  logic   sselActive;
  logic   frameStart;
  logic   frameEnd;
  logic   mosiBit;
  // receive path
  spiByte rxByte;
  logic   rxValid;
  // transmit path
  spiByte txByte;
  logic   txLoad;

  spiSync sync0 (
    .clk        (clk),
    .rst        (rst),
    .sck        (sck),
    .ssel       (ssel),
    .mosi       (mosi),
    .sckRise    (sckRise),
    .sckFall    (sckFall),
    .sselActive (sselActive),
    .frameStart (frameStart),
    .frameEnd   (frameEnd),
    .mosiBit    (mosiBit)
  );

  spiFrame frame0 (
    .clk        (clk),
    .rst        (rst),
    .sckRise    (sckRise),
    .sselActive (sselActive),
    .mosiBit    (mosiBit),
    .rxByte     (rxByte),
    .rxValid    (rxValid)
  );

  // frame edges go straight from the synchronizer
  regBank regs0 (
    .clk        (clk),
    .rst        (rst),
    .frameStart (frameStart),
    .frameEnd   (frameEnd),
    .rxByte     (rxByte),
    .rxValid    (rxValid),
    .txByte     (txByte),
    .txLoad     (txLoad),
    .led        (led)
  );

  spiTransmit transmit0 (
    .clk     (clk),
    .rst     (rst),
    .sckFall (sckFall),
    .txByte  (txByte),
    .txLoad  (txLoad),
    .miso    (miso)
  );

endmodule

/* rtl/regBank.sv */
// Register bank and command decoder
`include "spi_macros.svh"

module regBank (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 frameStart,
  input  logic                 frameEnd,
  input  spiTypes_pkg::spiByte rxByte,
  input  logic                 rxValid,
  output spiTypes_pkg::spiByte txByte,
  output logic                 txLoad,
  output regTypes_pkg::ledBits led
);

  import spiTypes_pkg::*;
  import regTypes_pkg::*;

  spiByte    regs [`SPI_NUM_REGS];
  frameState state;
  accessKind access;
  regAddr    addr;
  regAddr    nextAddr;
  regAddr    cmdAddr;
  accessKind cmdAccess;
  logic      cmdStrobe;
  logic      dataStrobe;

  // command byte fields, bits 6 to 3 unused
  assign cmdAddr   = rxByte[`SPI_ADDR_W-1:0];
  assign cmdAccess = rxByte[7] ? WRITE : READ;
  // wraps modulo the bank size
  assign nextAddr  = addr + 1'b1;

  // frame edges win over a byte
  assign cmdStrobe  = rxValid && !frameStart && !frameEnd && (state == CMD);
  assign dataStrobe = rxValid && !frameStart && !frameEnd && (state == DATA);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state  <= IDLE;
      access <= READ;
      addr   <= '0;
      txLoad <= 1'b0;
      led    <= '0;
      for (int i = 0; i < `SPI_NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      txLoad <= frameStart || cmdStrobe || dataStrobe;
      // leds trail register 0 by one clk
      led    <= regs[0][3:0];

      if (frameStart)
      begin
        state <= CMD;
      end
      else if (frameEnd)
      begin
        // a partial byte is simply dropped
        state <= IDLE;
      end
      else if (cmdStrobe)
      begin
        access <= cmdAccess;
        addr   <= cmdAddr;
        state  <= DATA;
      end
      else if (dataStrobe)
      begin
        if (access == WRITE)
        begin
          regs[addr] <= rxByte;
        end
        addr <= nextAddr;
      end
    end
  end

  // next byte for miso, picked up by the transmitter on txLoad
  always_ff @(posedge clk)
  begin
    if (frameStart)
    begin
      txByte <= `SPI_ID_BYTE;
    end
    else if (cmdStrobe)
    begin
      // read prefetches the start address, write sends zeros
      txByte <= (cmdAccess == WRITE) ? '0 : regs[cmdAddr];
    end
    else if (dataStrobe)
    begin
      txByte <= (access == WRITE) ? '0 : regs[nextAddr];
    end
  end

endmodule

/* spiCore/spiTransmit.sv */
// SPI byte transmitter
module spiTransmit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sckFall,
  input  spiTypes_pkg::spiByte txByte,
  input  logic                 txLoad,
  output logic                 miso
);

  import spiTypes_pkg::*;

  spiByte  txShift;
  // falling edges seen since the last load
  bitCount fallCnt;
  logic    loadPending;
  logic    lastBit;

  // after seven falls the last bit is on the line
  // it has to stay there until the falling edge that ends the byte
  assign lastBit = (fallCnt == '1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      txShift     <= '0;
      fallCnt     <= '0;
      loadPending <= 1'b0;
    end
    else
    begin
      if (txLoad && !lastBit)
      begin
        // frame start, no edge comes before the first bit
        txShift <= txByte;
        fallCnt <= '0;
      end
      else if (sckFall)
      begin
        if (loadPending)
        begin
          // closing edge of the old byte presents the new msb
          txShift     <= txByte;
          fallCnt     <= '0;
          loadPending <= 1'b0;
        end
        else
        begin
          txShift <= {txShift[6:0], 1'b0};
          fallCnt <= fallCnt + 1'b1;
        end
      end

      // defer while the last bit is still needed
      if (txLoad && lastBit)
      begin
        loadPending <= 1'b1;
      end
    end
  end

  // msb first, single slave so no tri-state
  assign miso = txShift[7];

endmodule

/* spiCore/spiFrame.sv */
// SPI byte receiver
module spiFrame (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sckRise,
  input  logic                 sselActive,
  input  logic                 mosiBit,
  output spiTypes_pkg::spiByte rxByte,
  output logic                 rxValid
);

  import spiTypes_pkg::*;

  bitCount bitCnt;
  spiByte  rxShift;

  // bit counter, held at zero outside a frame
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bitCnt <= '0;
    end
    else if (!sselActive)
    begin
      bitCnt <= '0;
    end
    else if (sckRise)
    begin
      bitCnt <= bitCnt + 1'b1;
    end
  end

  // msb arrives first, so shift in from the right
  always_ff @(posedge clk)
  begin
    if (sselActive && sckRise)
    begin
      rxShift <= {rxShift[6:0], mosiBit};
    end
  end

  // pulse one clk after the eighth rising edge
  // rxShift holds the full byte in that same cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rxValid <= 1'b0;
    end
    else
    begin
      rxValid <= sselActive && sckRise && (bitCnt == '1);
    end
  end

  assign rxByte = rxShift;

endmodule

/* rtl/spiSync.sv */
// SPI pin synchronizer
`include "spi_macros.svh"

module spiSync (
  input  logic clk,
  input  logic rst,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic sckRise,
  output logic sckFall,
  output logic sselActive,
  output logic frameStart,
  output logic frameEnd,
  output logic mosiBit
);

  localparam int syncDepth = `SPI_SYNC_DEPTH;

  // newest sample sits in bit 0
  logic [syncDepth-1:0] sckSync;
  logic [syncDepth-1:0] sselSync;
  logic [1:0]           mosiSync;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // sck idles low in mode 0
      sckSync  <= '0;
      // ssel idles high, so no false frame start out of reset
      sselSync <= '1;
      mosiSync <= '0;
    end
    else
    begin
      sckSync  <= {sckSync[syncDepth-2:0], sck};
      sselSync <= {sselSync[syncDepth-2:0], ssel};
      mosiSync <= {mosiSync[0], mosi};
    end
  end

  // compare the two oldest stages
  // a pin edge shows up here two clk later
  assign sckRise = (sckSync[syncDepth-1:syncDepth-2] == 2'b01);
  assign sckFall = (sckSync[syncDepth-1:syncDepth-2] == 2'b10);

  // select is active low
  assign sselActive = ~sselSync[syncDepth-2];
  // falling select opens a frame, rising select closes it
  assign frameStart = (sselSync[syncDepth-1:syncDepth-2] == 2'b10);
  assign frameEnd   = (sselSync[syncDepth-1:syncDepth-2] == 2'b01);

  // two stages keep mosi lined up with the sck strobes
  assign mosiBit = mosiSync[1];

endmodule

/* common/regTypes_pkg.sv */
// Register side types
`include "spi_macros.svh"

package regTypes_pkg;

  // index into the register bank
  // increments wrap modulo the bank size
  typedef logic [`SPI_ADDR_W-1:0] regAddr;

  // drives the board leds
  typedef logic [3:0] ledBits;

  // direction taken from bit 7 of the command byte
  typedef enum logic {
    READ,
    WRITE
  } accessKind;

  // where we are inside a frame
  typedef enum logic [1:0] {
    IDLE,
    CMD,
    DATA
  } frameState;

endpackage

/* common/spiTypes_pkg.sv */
// Serial side types
package spiTypes_pkg;

  // one byte as it moves over the wire
  typedef logic [7:0] spiByte;

  // bit position inside a byte
  // wraps by itself after the eighth bit
  typedef logic [2:0] bitCount;

endpackage

/* common/spi_macros.svh */
// SPI peripheral constants
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// size of the register bank
`define SPI_NUM_REGS 8

// address bits needed to pick one register
`define SPI_ADDR_W 3

// identity byte, shifted out while the command byte comes in
`define SPI_ID_BYTE 8'hA5

// flops in the sck and ssel synchronizers
// edge detect looks at the two oldest ones
`define SPI_SYNC_DEPTH 3

`endif
